//--- src.f
+incdir+.
gem_clct_pkg.sv
bend_angle_calc.sv
tree_encoder_alctclctgem.sv
match_window_timer.sv
match_fsm.sv
best_match_accum.sv
gem_clct_match_top.sv
tb_gem_clct_match.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the GEM-CLCT matching testbench with Verilator.
# The run passes only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
    --top-module tb_gem_clct_match -Mdir obj_dir -f src.f \
  && ./obj_dir/Vtb_gem_clct_match | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }

//--- tb_gem_clct_checks.svh
`ifndef TB_GEM_CLCT_CHECKS_SVH
`define TB_GEM_CLCT_CHECKS_SVH

logic [31:0] lcg_state = 32'hce05_cc2f;

logic [7:0]  stim_vld [0:6];                // Pad valids per crossing.
logic [9:0]  stim_xky [0:6][0:7];           // Pad positions per crossing.

// Model result for the current window.
logic        exp_any;
logic        exp_found;
logic [9:0]  exp_angle;
logic [2:0]  exp_pad;
logic [2:0]  exp_bx;
logic [9:0]  exp_xky;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic logic [9:0] random_key();
  logic [31:0] r;
  r = lcg_next();
  return 10'd200 + 10'(r[31:16] % 16'd600);   // Keeps clusters from wrapping.
endfunction

// Absolute difference, capped one below the invalid marker.
function automatic logic [9:0] ref_angle(input logic [9:0] gem, input logic [9:0] key);
  int d;
  d = int'(gem) - int'(key);
  if (d < 0)
    d = -d;
  if (d > int'(`NO_CAND_ANGLE) - 1)
    d = int'(`NO_CAND_ANGLE) - 1;
  return d[9:0];
endfunction

task automatic clear_stim();
  for (int b = 0; b < 7; b++)
  begin
    stim_vld[b] = '0;
    for (int p = 0; p < 8; p++)
      stim_xky[b][p] = '0;
  end
endtask

task automatic set_pad(input int b, input int p, input logic [9:0] x);
  stim_vld[b][p] = 1'b1;
  stim_xky[b][p] = x;
endtask

// Coarse steps of 8 make equal angles common.
task automatic fill_random_crossing(input int b, input logic [9:0] key);
  logic [31:0] r;
  for (int p = 0; p < 8; p++)
  begin
    r              = lcg_next();
    stim_vld[b][p] = r[31];
    stim_xky[b][p] = key + {2'b00, r[23:19], 3'b000} - 10'd128;
  end
endtask

task automatic drive_crossing(input int b);
  gem_vld = stim_vld[b];
  for (int p = 0; p < 8; p++)
    gem_xky[p] = stim_xky[b][p];
endtask

// Scan crossings then pads in order; strict less keeps the earliest and lowest.
task automatic compute_expected(input logic [9:0] key);
  logic [9:0] a;
  exp_any   = 1'b0;
  exp_angle = `NO_CAND_ANGLE;
  exp_pad   = '0;
  exp_bx    = '0;
  exp_xky   = '0;
  for (int b = 0; b < W; b++)
  begin
    for (int p = 0; p < 8; p++)
    begin
      if (stim_vld[b][p])
      begin
        a = ref_angle(stim_xky[b][p], key);
        if (a < exp_angle)
        begin
          exp_any   = 1'b1;
          exp_angle = a;
          exp_pad   = 3'(p);
          exp_bx    = 3'(b);
          exp_xky   = stim_xky[b][p];
        end
      end
    end
  end
  exp_found = exp_any && (exp_angle < `MAX_ANGLE);
endtask

task automatic report_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
  $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
  abort_run($sformatf("wrong value on %s at %0t", name, $time));
endtask

task automatic check_report();
  assert (match_found == exp_found)
    else report_mismatch("match_found", 32'(match_found), 32'(exp_found));
  assert (match_angle == exp_angle)
    else report_mismatch("match_angle", 32'(match_angle), 32'(exp_angle));
  if (exp_any)
  begin
    assert (match_pad == exp_pad)
      else report_mismatch("match_pad", 32'(match_pad), 32'(exp_pad));
    assert (match_bx == exp_bx)
      else report_mismatch("match_bx", 32'(match_bx), 32'(exp_bx));
    assert (match_gem_xky == exp_xky)
      else report_mismatch("match_gem_xky", 32'(match_gem_xky), 32'(exp_xky));
  end
endtask

`endif

//--- tb_gem_clct_match.sv
`timescale 1ns/10ps
`default_nettype none

`include "gem_clct_config.svh"

module tb_gem_clct_match;

  localparam int W            = int'(`MATCH_WINDOW);
  localparam int NUM_DIRECTED = 8;                      // Directed windows.
  localparam int NUM_RANDOM   = 20;                     // Random windows of each kind.
  localparam int NUM_TRIALS   = NUM_DIRECTED + 2 * NUM_RANDOM;
  localparam int WATCHDOG_NS  = (NUM_TRIALS * (W + 5) + 20) * 40;

  logic                     clock = 1'b0;
  logic                     reset;
  logic                     clct_vld;
  gem_clct_pkg::xky_t       clct_xky;
  logic [7:0]               gem_vld;
  gem_clct_pkg::xky_t [7:0] gem_xky;
  logic                     busy;
  logic                     match_vld;
  logic                     match_found;
  gem_clct_pkg::pad_idx_t   match_pad;
  gem_clct_pkg::bx_cnt_t    match_bx;
  gem_clct_pkg::angle_t     match_angle;
  gem_clct_pkg::xky_t       match_gem_xky;

  int trial_count  = 0;
  int report_count = 0;

  `include "tb_gem_clct_checks.svh"

  gem_clct_match_top uut
  (
    .clock         (clock),
    .reset         (reset),
    .clct_vld      (clct_vld),
    .clct_xky      (clct_xky),
    .gem_vld       (gem_vld),
    .gem_xky       (gem_xky),
    .busy          (busy),
    .match_vld     (match_vld),
    .match_found   (match_found),
    .match_pad     (match_pad),
    .match_bx      (match_bx),
    .match_angle   (match_angle),
    .match_gem_xky (match_gem_xky)
  );

  always #20 clock = ~clock;                            // 40 ns period.

  always @(posedge clock)
  begin
    if (!reset && match_vld)
      report_count <= report_count + 1;
  end

  // Report strobe is a single cycle and only while busy.
  assert property (@(posedge clock) disable iff (reset) match_vld |=> !match_vld)
    else abort_run("match_vld stayed high for more than one cycle");
  assert property (@(posedge clock) disable iff (reset) match_vld |-> busy)
    else abort_run("match_vld was raised while busy was low");

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // Second CLCT at negedge extra_k when extra_k is nonzero.
  task automatic run_window(input logic [9:0] key, input int extra_k, input logic [9:0] extra_key);
    logic [31:0] r;
    compute_expected(key);
    trial_count++;
    @(negedge clock);
    r        = lcg_next();
    clct_vld = 1'b1;
    clct_xky = key;
    gem_vld  = r[15:8];                                 // Noise before the window.
    for (int p = 0; p < 8; p++)
      gem_xky[p] = r[25:16];
    for (int k = 1; k <= W + 4; k++)
    begin
      @(negedge clock);
      assert (busy == (k <= W + 2))
        else report_mismatch("busy", 32'(busy), 32'(k <= W + 2));
      assert (match_vld == (k == W + 2))
        else report_mismatch("match_vld", 32'(match_vld), 32'(k == W + 2));
      if (k == W + 2)
        check_report();
      clct_vld = (k == extra_k);
      clct_xky = (k == extra_k) ? extra_key : key;
      if (k <= W)
        drive_crossing(k - 1);
      else if (k == W + 1)
        gem_vld = ~r[15:8];                             // Noise after the window.
      else
        gem_vld = '0;
    end
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    abort_run("watchdog timeout, the run did not finish in time");
  end

  initial
  begin
    logic [9:0] key;
    reset    = 1'b1;
    clct_vld = 1'b0;
    clct_xky = '0;
    gem_vld  = '0;
    gem_xky  = '0;
    clear_stim();
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      @(negedge clock);
      assert (!match_vld && !busy && !match_found)
        else abort_run("DUT left idle after reset without a CLCT");
    end
    clear_stim();                                       // Equal angles on pads 2 and 5.
    set_pad(0, 2, 10'd110);
    set_pad(0, 5, 10'd90);
    set_pad(0, 0, 10'd400);
    run_window(10'd100, 0, 10'd0);
    clear_stim();                                       // Equal angles over crossings.
    set_pad(0, 6, 10'd505);
    set_pad(1, 0, 10'd495);
    set_pad(2, 3, 10'd505);
    run_window(10'd500, 0, 10'd0);
    clear_stim();
    run_window(10'd300, 0, 10'd0);                      // No clusters at all.
    set_pad(0, 4, 10'd364);
    run_window(10'd300, 0, 10'd0);                      // Angle equal to the cut.
    clear_stim();
    set_pad(0, 1, 10'd237);
    run_window(10'd300, 0, 10'd0);                      // Just inside the cut.
    clear_stim();
    set_pad(0, 2, 10'd305);
    run_window(10'd300, 1, 10'd600);                    // Second CLCT while busy.
    clear_stim();
    set_pad(0, 3, 10'd1023);
    run_window(10'd0, 0, 10'd0);                        // Saturated angle.
    clear_stim();
    set_pad(0, 1, 10'd0);
    run_window(10'd1023, 0, 10'd0);
    for (int t = 0; t < NUM_RANDOM; t++)
    begin
      clear_stim();
      key = random_key();
      fill_random_crossing(0, key);
      run_window(key, 0, 10'd0);
    end
    for (int t = 0; t < NUM_RANDOM; t++)
    begin
      clear_stim();
      key = random_key();
      for (int b = 0; b < W; b++)
        fill_random_crossing(b, key);
      run_window(key, 0, 10'd0);
    end
    repeat (3) @(negedge clock);
    if (report_count == trial_count)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
      abort_run("number of reports differs from the number of accepted CLCTs");
  end

endmodule

`default_nettype wire

//--- gem_clct_match_top.sv
`timescale 1ns/10ps
`default_nettype none

module gem_clct_match_top
(
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     clct_vld,
  input  gem_clct_pkg::xky_t       clct_xky,
  input  logic [7:0]               gem_vld,
  input  gem_clct_pkg::xky_t [7:0] gem_xky,
  output logic                     busy,
  output logic                     match_vld,
  output logic                     match_found,
  output gem_clct_pkg::pad_idx_t   match_pad,
  output gem_clct_pkg::bx_cnt_t    match_bx,
  output gem_clct_pkg::angle_t     match_angle,
  output gem_clct_pkg::xky_t       match_gem_xky
);

  logic                       window_start;
  logic                       window_open;
  logic                       window_done;
  gem_clct_pkg::bx_cnt_t      bx_count;

  gem_clct_pkg::angle_t [7:0] cand_pri;
  gem_clct_pkg::xky_t [7:0]   cand_xky;
  logic                       cand_vld;

  gem_clct_pkg::angle_t       pri_best;
  gem_clct_pkg::pad_idx_t     win_best;
  gem_clct_pkg::xky_t         gem_xky_best;

  match_fsm u_fsm
  (
    .clock        (clock),
    .reset        (reset),
    .clct_vld     (clct_vld),
    .window_done  (window_done),
    .window_start (window_start),
    .window_open  (window_open),
    .report       (match_vld),    // Result strobe.
    .busy         (busy)
  );

  match_window_timer u_timer
  (
    .clock    (clock),
    .reset    (reset),
    .start    (window_start),
    .bx_count (bx_count),
    .done     (window_done)
  );

  bend_angle_calc u_bend
  (
    .clock        (clock),
    .reset        (reset),
    .window_start (window_start),
    .clct_xky     (clct_xky),
    .gem_vld      (gem_vld),
    .gem_xky      (gem_xky),
    .cand_pri     (cand_pri),
    .cand_xky     (cand_xky),
    .cand_vld     (cand_vld)
  );

  tree_encoder_alctclctgem u_tree
  (
    .win_pri_0    (cand_pri[0]),
    .win_pri_1    (cand_pri[1]),
    .win_pri_2    (cand_pri[2]),
    .win_pri_3    (cand_pri[3]),
    .win_pri_4    (cand_pri[4]),
    .win_pri_5    (cand_pri[5]),
    .win_pri_6    (cand_pri[6]),
    .win_pri_7    (cand_pri[7]),
    .gem_xky_0    (cand_xky[0]),
    .gem_xky_1    (cand_xky[1]),
    .gem_xky_2    (cand_xky[2]),
    .gem_xky_3    (cand_xky[3]),
    .gem_xky_4    (cand_xky[4]),
    .gem_xky_5    (cand_xky[5]),
    .gem_xky_6    (cand_xky[6]),
    .gem_xky_7    (cand_xky[7]),
    .gem_xky_best (gem_xky_best),
    .win_best     (win_best),
    .pri_best     (pri_best)
  );

  best_match_accum u_accum
  (
    .clock        (clock),
    .reset        (reset),
    .window_start (window_start),
    .window_open  (window_open),
    .cand_vld     (cand_vld),
    .pri_in       (pri_best),
    .win_in       (win_best),
    .xky_in       (gem_xky_best),
    .bx_in        (bx_count),
    .best_pri     (match_angle),
    .best_pad     (match_pad),
    .best_xky     (match_gem_xky),
    .best_bx      (match_bx),
    .found        (match_found)
  );

endmodule

`default_nettype wire

//--- best_match_accum.sv
`timescale 1ns/10ps
`default_nettype none

`include "gem_clct_config.svh"

module best_match_accum
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   window_start,
  input  logic                   window_open,
  input  logic                   cand_vld,
  input  gem_clct_pkg::angle_t   pri_in,
  input  gem_clct_pkg::pad_idx_t win_in,
  input  gem_clct_pkg::xky_t     xky_in,
  input  gem_clct_pkg::bx_cnt_t  bx_in,
  output gem_clct_pkg::angle_t   best_pri,
  output gem_clct_pkg::pad_idx_t best_pad,
  output gem_clct_pkg::xky_t     best_xky,
  output gem_clct_pkg::bx_cnt_t  best_bx,
  output logic                   found
);

  logic taken;                       // Some candidate held.
  logic take;

  // Strictly smaller only, earlier crossing keeps a tie.
  assign take = window_open && cand_vld && (pri_in < best_pri);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      best_pri <= `NO_CAND_ANGLE;
      taken    <= 1'b0;
    end
    else if (window_start)
    begin
      best_pri <= `NO_CAND_ANGLE;   // Fresh window.
      taken    <= 1'b0;
    end
    else if (take)
    begin
      best_pri <= pri_in;
      taken    <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (take)
    begin
      best_pad <= win_in;
      best_xky <= xky_in;
      best_bx  <= bx_in;
    end
  end

  assign found = taken && (best_pri < `MAX_ANGLE);   // Inside the cut.

endmodule

`default_nettype wire

//--- match_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module match_fsm
(
  input  logic clock,
  input  logic reset,
  input  logic clct_vld,
  input  logic window_done,
  output logic window_start,
  output logic window_open,
  output logic report,
  output logic busy
);

  gem_clct_pkg::match_state_t state;
  gem_clct_pkg::match_state_t next_state;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state       <= gem_clct_pkg::IDLE;
      window_open <= 1'b0;
    end
    else
    begin
      state       <= next_state;
      // Opens one cycle after accept, when the first candidate lands.
      window_open <= (state == gem_clct_pkg::WINDOW) && !window_done;
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      gem_clct_pkg::IDLE:
      begin
        if (clct_vld)
          next_state = gem_clct_pkg::WINDOW;
      end
      gem_clct_pkg::WINDOW:
      begin
        if (window_done)
          next_state = gem_clct_pkg::REPORT;
      end
      gem_clct_pkg::REPORT:
      begin
        next_state = gem_clct_pkg::IDLE;   // Single report cycle.
      end
      default:
      begin
        next_state = gem_clct_pkg::IDLE;
      end
    endcase
  end

  assign window_start = (state == gem_clct_pkg::IDLE) && clct_vld;  // CLCT accepted.
  assign report       = (state == gem_clct_pkg::REPORT);
  assign busy         = (state != gem_clct_pkg::IDLE);               // Later CLCTs dropped.

endmodule

`default_nettype wire

//--- match_window_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "gem_clct_config.svh"

module match_window_timer
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  output gem_clct_pkg::bx_cnt_t bx_count,
  output logic                  done
);

  gem_clct_pkg::bx_cnt_t cnt;      // Cycles since the accept edge.
  logic                  running;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      cnt     <= '0;
      running <= 1'b0;
    end
    else if (start)
    begin
      cnt     <= '0;
      running <= 1'b1;
    end
    else if (running)
    begin
      if (done)
        running <= 1'b0;         // Window closed.
      else
        cnt <= cnt + 3'd1;
    end
  end

  assign done = running && (cnt == `MATCH_WINDOW);

  // Candidate at the accumulator lags the GEM sample by one.
  assign bx_count = cnt - 3'd1;

endmodule

`default_nettype wire

//--- tree_encoder_alctclctgem.sv
`timescale 1ns/10ps
`default_nettype none

// Picks the pad with the smallest bending angle, lowest pad on a tie.
module tree_encoder_alctclctgem
(
  input  gem_clct_pkg::angle_t   win_pri_0,    // Bending angle per pad.
  input  gem_clct_pkg::angle_t   win_pri_1,
  input  gem_clct_pkg::angle_t   win_pri_2,
  input  gem_clct_pkg::angle_t   win_pri_3,
  input  gem_clct_pkg::angle_t   win_pri_4,
  input  gem_clct_pkg::angle_t   win_pri_5,
  input  gem_clct_pkg::angle_t   win_pri_6,
  input  gem_clct_pkg::angle_t   win_pri_7,

  input  gem_clct_pkg::xky_t     gem_xky_0,    // GEM position per pad.
  input  gem_clct_pkg::xky_t     gem_xky_1,
  input  gem_clct_pkg::xky_t     gem_xky_2,
  input  gem_clct_pkg::xky_t     gem_xky_3,
  input  gem_clct_pkg::xky_t     gem_xky_4,
  input  gem_clct_pkg::xky_t     gem_xky_5,
  input  gem_clct_pkg::xky_t     gem_xky_6,
  input  gem_clct_pkg::xky_t     gem_xky_7,

  output gem_clct_pkg::xky_t     gem_xky_best,
  output gem_clct_pkg::pad_idx_t win_best,
  output gem_clct_pkg::angle_t   pri_best
);

  logic                 win_s1     [3:0];      // Odd pad won the pair.
  gem_clct_pkg::angle_t pri_s1     [3:0];
  gem_clct_pkg::xky_t   gem_xky_s1 [3:0];

  // Stage one, odd pad only when strictly smaller.
  assign win_s1[3]     = (win_pri_7 < win_pri_6);
  assign pri_s1[3]     = win_s1[3] ? win_pri_7 : win_pri_6;
  assign gem_xky_s1[3] = win_s1[3] ? gem_xky_7 : gem_xky_6;

  assign win_s1[2]     = (win_pri_5 < win_pri_4);
  assign pri_s1[2]     = win_s1[2] ? win_pri_5 : win_pri_4;
  assign gem_xky_s1[2] = win_s1[2] ? gem_xky_5 : gem_xky_4;

  assign win_s1[1]     = (win_pri_3 < win_pri_2);
  assign pri_s1[1]     = win_s1[1] ? win_pri_3 : win_pri_2;
  assign gem_xky_s1[1] = win_s1[1] ? gem_xky_3 : gem_xky_2;

  assign win_s1[0]     = (win_pri_1 < win_pri_0);
  assign pri_s1[0]     = win_s1[0] ? win_pri_1 : win_pri_0;
  assign gem_xky_s1[0] = win_s1[0] ? gem_xky_1 : gem_xky_0;

  // Stage two, a higher group must beat every lower one.
  always_comb
  begin
    if ((pri_s1[3] < pri_s1[2]) && (pri_s1[3] < pri_s1[1]) && (pri_s1[3] < pri_s1[0]))
    begin
      pri_best     = pri_s1[3];
      win_best     = {2'd3, win_s1[3]};
      gem_xky_best = gem_xky_s1[3];
    end
    else if ((pri_s1[2] < pri_s1[1]) && (pri_s1[2] < pri_s1[0]))
    begin
      pri_best     = pri_s1[2];
      win_best     = {2'd2, win_s1[2]};
      gem_xky_best = gem_xky_s1[2];
    end
    else if (pri_s1[1] < pri_s1[0])
    begin
      pri_best     = pri_s1[1];
      win_best     = {2'd1, win_s1[1]};
      gem_xky_best = gem_xky_s1[1];
    end
    else
    begin
      pri_best     = pri_s1[0];
      win_best     = {2'd0, win_s1[0]};
      gem_xky_best = gem_xky_s1[0];
    end
  end

endmodule

`default_nettype wire

//--- bend_angle_calc.sv
`timescale 1ns/10ps
`default_nettype none

`include "gem_clct_config.svh"

module bend_angle_calc
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       window_start,
  input  gem_clct_pkg::xky_t         clct_xky,
  input  logic [7:0]                 gem_vld,
  input  gem_clct_pkg::xky_t [7:0]   gem_xky,
  output gem_clct_pkg::angle_t [7:0] cand_pri,
  output gem_clct_pkg::xky_t [7:0]   cand_xky,
  output logic                       cand_vld
);

  gem_clct_pkg::xky_t key_xky;       // CLCT key held for the window.
  logic [7:0]         vld_q;         // Registered pad valids.

  // Absolute difference, kept clear of the invalid marker.
  function automatic gem_clct_pkg::angle_t bend_angle
  (
    input gem_clct_pkg::xky_t gem,
    input gem_clct_pkg::xky_t key
  );
    gem_clct_pkg::angle_t diff;
    diff = (gem > key) ? (gem - key) : (key - gem);
    if (diff >= `NO_CAND_ANGLE)
    begin
      diff = `NO_CAND_ANGLE - 10'd1; // Saturate.
    end
    return diff;
  endfunction

  always_ff @(posedge clock)
  begin
    if (window_start)
    begin
      key_xky <= clct_xky;           // Latch key on accept.
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      vld_q <= '0;
    end
    else
    begin
      vld_q <= gem_vld;
    end
  end

  // Per-pad angle stage.
  always_ff @(posedge clock)
  begin
    for (int i = 0; i < 8; i++)
    begin
      cand_xky[i] <= gem_xky[i];
      cand_pri[i] <= gem_vld[i] ? bend_angle(gem_xky[i], key_xky) : `NO_CAND_ANGLE;
    end
  end

  assign cand_vld = |vld_q;          // Any pad valid this crossing.

endmodule

`default_nettype wire

//--- gem_clct_pkg.sv
`default_nettype none

package gem_clct_pkg;

  // Position in eighth-strip units.
  typedef logic [9:0] xky_t;

  // Bending angle, |GEM - CLCT| position.
  typedef logic [9:0] angle_t;

  typedef logic [2:0] pad_idx_t;   // GEM pad index 0..7.
  typedef logic [2:0] bx_cnt_t;    // Crossing inside the window.

  typedef enum logic [1:0]
  {
    IDLE,                          // Waiting for a CLCT.
    WINDOW,                        // Collecting GEM clusters.
    REPORT                         // One-cycle result strobe.
  } match_state_t;

endpackage

`default_nettype wire

//--- gem_clct_config.svh
`ifndef GEM_CLCT_CONFIG_SVH
`define GEM_CLCT_CONFIG_SVH

// GEM crossings per window, legal 1 to 7.
`define MATCH_WINDOW 3'd3

// Match needs an angle strictly below this cut.
`define MAX_ANGLE 10'd64

// Marks an invalid pad; real angles saturate one below.
`define NO_CAND_ANGLE 10'h3ff

`endif
